//--- behavior_controller.f
verilog/nav_fixed_pkg.sv
verilog/nav_fsm_pkg.sv
verilog/proximity_classify.sv
verilog/avoid_fsm.sv
verilog/motion_decode.sv
verilog/behavior_controller.sv
bench/behavior_controller_assert.sv
bench/behavior_controller_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the behavior controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module behavior_controller_tb \
	-f behavior_controller.f --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vbehavior_controller_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1

//--- bench/behavior_controller_tb.sv
//==========================================================
// behavior controller testbench
// random sensor and goal-error stimulus, a reference model
// of the behavior FSM and a per-cycle check of every output
//==========================================================
`timescale 1ns/10ps

module behavior_controller_tb;

	localparam nav_fixed_pkg::sm_word_t safe_dist = nav_fixed_pkg::default_safe_dist;
	localparam nav_fixed_pkg::sm_word_t err_tol = nav_fixed_pkg::default_err_tol;
	localparam nav_fixed_pkg::sm_word_t vel_mag = nav_fixed_pkg::default_vel_mag;
	localparam int sign_weight = 1 << (nav_fixed_pkg::word_width - 1);
	localparam int mag_mask = sign_weight - 1;
	localparam int reset_cycles = 3;
	localparam int num_cycles = 4000;
	localparam int cycle_limit = reset_cycles + num_cycles + 97; // run length plus margin

	typedef enum int
	{
		m_reset, m_start, m_goal, m_check_0, m_check_1, m_check_2, m_check_3,
		m_right_0, m_wait_0, m_clear_0, m_right_1, m_wait_1, m_clear_1,
		m_fwd_in_2, m_fwd_2, m_wait_f2, m_clear_f2, m_right_2, m_wait_r2, m_clear_r2,
		m_fwd_in_3, m_fwd_3, m_wait_f3, m_clear_f3, m_left_3, m_wait_l3, m_clear_l3
	} model_state_e;

	logic clk;
	logic rst;
	nav_fixed_pkg::sm_word_t dist_1;
	nav_fixed_pkg::sm_word_t dist_2;
	nav_fixed_pkg::sm_word_t dist_3;
	nav_fixed_pkg::sm_word_t dist_4;
	nav_fixed_pkg::sm_word_t err_x;
	nav_fixed_pkg::sm_word_t err_y;
	logic time_flag_n;
	nav_fixed_pkg::sm_word_t vel_x;
	nav_fixed_pkg::sm_word_t vel_y;
	logic enable_time_n;
	logic clear_time_n;
	logic behavior;
	logic [7:0] current_beh;

	integer seed;
	int cycle;
	int timeout_count;
	int missed;
	int hits [4];
	model_state_e model_state;
	model_state_e prev_state;

	behavior_controller #(.safe_dist(safe_dist), .err_tol(err_tol), .vel_mag(vel_mag)) uut
	(
		.SC_STATEMACHINE_DESC_CLOCK_50(clk), .SC_STATEMACHINE_DESC_RESET_InHigh(rst),
		.dist_1(dist_1), .dist_2(dist_2), .dist_3(dist_3), .dist_4(dist_4),
		.err_x(err_x), .err_y(err_y), .time_flag_n(time_flag_n),
		.vel_x(vel_x), .vel_y(vel_y), .enable_time_n(enable_time_n),
		.clear_time_n(clear_time_n), .behavior(behavior), .current_beh(current_beh)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fffffff) % n;
	endfunction

	// model of the FSM rules, flags taken from the applied inputs
	function automatic model_state_e next_state(input model_state_e s);
		logic n1;
		logic n2;
		logic n3;
		logic n4;
		logic xneg;
		logic yneg;
		logic ysmall;
		n1 = (dist_1 <= safe_dist);
		n2 = (dist_2 <= safe_dist);
		n3 = (dist_3 <= safe_dist);
		n4 = (dist_4 <= safe_dist);
		xneg = err_x[nav_fixed_pkg::word_width-1];
		yneg = err_y[nav_fixed_pkg::word_width-1];
		ysmall = ((int'(err_y) & mag_mask) <= (int'(err_tol) & mag_mask));
		case (s)
			m_reset: return m_start;
			m_start: return m_goal;
			m_goal: return (n1 | n2 | n3 | n4) ? m_check_0 : m_goal;
			m_check_0: return yneg ? m_check_1 : m_right_0;
			m_check_1: return yneg ? m_right_1 : m_check_2;
			m_check_2: return (!xneg && ysmall) ? m_fwd_in_2 : m_check_3;
			m_check_3: return (xneg && ysmall) ? m_fwd_in_3 : m_goal;
			m_right_0: return n1 ? m_right_0 : m_wait_0;
			m_wait_0: return time_flag_n ? m_wait_0 : m_clear_0;
			m_right_1: return n3 ? m_right_1 : m_wait_1;
			m_wait_1: return time_flag_n ? m_wait_1 : m_clear_1;
			m_fwd_in_2: return n2 ? m_fwd_2 : m_goal; // side already clear
			m_fwd_2: return n2 ? m_fwd_2 : m_wait_f2;
			m_wait_f2: return time_flag_n ? m_wait_f2 : m_clear_f2;
			m_clear_f2: return m_right_2;
			m_right_2: return n3 ? m_right_2 : m_wait_r2;
			m_wait_r2: return time_flag_n ? m_wait_r2 : m_clear_r2;
			m_fwd_in_3: return n4 ? m_fwd_3 : m_goal;
			m_fwd_3: return n4 ? m_fwd_3 : m_wait_f3;
			m_wait_f3: return time_flag_n ? m_wait_f3 : m_clear_f3;
			m_clear_f3: return m_left_3;
			m_left_3: return n3 ? m_left_3 : m_wait_l3;
			m_wait_l3: return time_flag_n ? m_wait_l3 : m_clear_l3;
			default: return m_goal; // every clear state that ends a detour
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("mismatch %s at cycle %0d: expected %0h, actual %0h",
				name, cycle, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "output check failed");
		end
	endtask

	//==========================================================
	// expected outputs of the model state
	//==========================================================
	task automatic check_outputs;
		int exp_vx;
		int exp_vy;
		int exp_en;
		int exp_clr;
		int exp_beh;
		exp_vx = 0;
		exp_vy = 0;
		exp_en = 1;
		exp_clr = 1;
		exp_beh = 0;
		case (model_state)
			m_reset, m_start, m_goal, m_check_0, m_check_1, m_check_2, m_check_3:
				exp_beh = 1;
			m_right_0, m_wait_0, m_clear_0, m_right_1, m_wait_1, m_clear_1,
			m_right_2, m_wait_r2, m_clear_r2:
				exp_vy = sign_weight | (int'(vel_mag) & mag_mask); // negative y
			m_left_3, m_wait_l3, m_clear_l3:
				exp_vy = int'(vel_mag);
			default:
				exp_vx = int'(vel_mag); // forward legs
		endcase
		case (model_state)
			m_wait_0, m_wait_1, m_wait_f2, m_wait_r2, m_wait_f3, m_wait_l3:
				exp_en = 0;
			m_clear_0, m_clear_1, m_clear_f2, m_clear_r2, m_clear_f3, m_clear_l3:
				exp_clr = 0;
			default:
				;
		endcase
		compare("vel_x", exp_vx, 32'(vel_x));
		compare("vel_y", exp_vy, 32'(vel_y));
		compare("enable_time_n", exp_en, 32'(enable_time_n));
		compare("clear_time_n", exp_clr, 32'(clear_time_n));
		compare("behavior", exp_beh, 32'(behavior));
		compare("current_beh", (exp_beh != 0) ? 50 : 100, 32'(current_beh));
	endtask

	task automatic drive_random;
		int sign;
		dist_1 = nav_fixed_pkg::sm_word_t'(int'(safe_dist) - 256 + rand_below(768)); // ~1/3 near
		dist_2 = nav_fixed_pkg::sm_word_t'(int'(safe_dist) - 256 + rand_below(768));
		dist_3 = nav_fixed_pkg::sm_word_t'(int'(safe_dist) - 256 + rand_below(768));
		dist_4 = nav_fixed_pkg::sm_word_t'(int'(safe_dist) - 256 + rand_below(768));
		sign = rand_below(2) * sign_weight;
		err_x = nav_fixed_pkg::sm_word_t'(sign | (int'(err_tol) - 1024 + rand_below(2048)));
		sign = rand_below(2) * sign_weight;
		err_y = nav_fixed_pkg::sm_word_t'(sign | (int'(err_tol) - 1024 + rand_below(2048)));
		time_flag_n = (rand_below(4) != 0); // low about one cycle in four
	endtask

	initial
	begin
		timeout_count = 0;
		while (timeout_count < cycle_limit)
		begin
			@(posedge clk);
			timeout_count++;
		end
		$display("timeout: run still going after %0d cycles", cycle_limit);
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

	initial
	begin
		seed = 78;
		rst = 1'b1;
		time_flag_n = 1'b1;
		dist_1 = nav_fixed_pkg::sm_word_t'(mag_mask); // far away
		dist_2 = nav_fixed_pkg::sm_word_t'(mag_mask);
		dist_3 = nav_fixed_pkg::sm_word_t'(mag_mask);
		dist_4 = nav_fixed_pkg::sm_word_t'(mag_mask);
		err_x = '0;
		err_y = '0;
		hits = '{0, 0, 0, 0};
		model_state = m_reset;
		for (cycle = 0; cycle < reset_cycles + num_cycles; cycle++)
		begin
			@(posedge clk);
			prev_state = model_state;
			model_state = rst ? m_reset : next_state(prev_state);
			if (model_state != prev_state)
			begin
				case (model_state)
					m_right_0: hits[0]++;
					m_right_1: hits[1]++;
					m_fwd_in_2: hits[2]++;
					m_fwd_in_3: hits[3]++;
					default: ;
				endcase
			end
			#5;
			check_outputs();
			if (cycle == reset_cycles - 1)
				rst = 1'b0;
			if (!rst)
				drive_random();
		end
		missed = 0;
		for (int i = 0; i < 4; i++)
		begin
			if (hits[i] == 0)
			begin
				$display("detour %0d was never entered", i);
				missed++;
			end
		end
		if (missed != 0)
		begin
			$display("RESULT: FAIL");
			$fatal(1, "detour coverage incomplete");
		end
		else
		begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

//--- bench/behavior_controller_assert.sv
//==========================================================
// behavior controller output rules
// timer strobes exclusive, standstill in go-to-goal and a
// behavior code that follows the behavior flag
//==========================================================
`timescale 1ns/10ps

module behavior_controller_assert
(
	input logic SC_STATEMACHINE_DESC_CLOCK_50,
	input logic SC_STATEMACHINE_DESC_RESET_InHigh,
	input nav_fixed_pkg::sm_word_t vel_x,
	input nav_fixed_pkg::sm_word_t vel_y,
	input logic enable_time_n,
	input logic clear_time_n,
	input logic behavior,
	input logic [7:0] current_beh
);

	strobe_exclusive: assert property (@(posedge SC_STATEMACHINE_DESC_CLOCK_50)
		disable iff (SC_STATEMACHINE_DESC_RESET_InHigh) (enable_time_n || clear_time_n))
		else $error("timer enable and clear active together");

	goal_standstill: assert property (@(posedge SC_STATEMACHINE_DESC_CLOCK_50)
		behavior |-> (vel_x == '0 && vel_y == '0))
		else $error("velocity commanded in go-to-goal");

	code_follows_flag: assert property (@(posedge SC_STATEMACHINE_DESC_CLOCK_50)
		((current_beh == 8'd50) == behavior))
		else $error("behavior code disagrees with behavior flag");

endmodule

bind behavior_controller behavior_controller_assert u_assert
(
	.SC_STATEMACHINE_DESC_CLOCK_50(SC_STATEMACHINE_DESC_CLOCK_50),
	.SC_STATEMACHINE_DESC_RESET_InHigh(SC_STATEMACHINE_DESC_RESET_InHigh),
	.vel_x(vel_x), .vel_y(vel_y), .enable_time_n(enable_time_n),
	.clear_time_n(clear_time_n), .behavior(behavior), .current_beh(current_beh)
);

//--- verilog/behavior_controller.sv
//==========================================================
// robot behavior controller
// go-to-goal or obstacle avoidance from four range sensors
// and the goal errors, with an external wait timer
//==========================================================
`timescale 1ns/10ps

module behavior_controller
#(
	parameter nav_fixed_pkg::sm_word_t safe_dist = nav_fixed_pkg::default_safe_dist,
	parameter nav_fixed_pkg::sm_word_t err_tol = nav_fixed_pkg::default_err_tol,
	parameter nav_fixed_pkg::sm_word_t vel_mag = nav_fixed_pkg::default_vel_mag
)
(
	input  logic SC_STATEMACHINE_DESC_CLOCK_50,
	input  logic SC_STATEMACHINE_DESC_RESET_InHigh,
	input  nav_fixed_pkg::sm_word_t dist_1,
	input  nav_fixed_pkg::sm_word_t dist_2,
	input  nav_fixed_pkg::sm_word_t dist_3,
	input  nav_fixed_pkg::sm_word_t dist_4,
	input  nav_fixed_pkg::sm_word_t err_x,
	input  nav_fixed_pkg::sm_word_t err_y,
	input  logic time_flag_n,
	output nav_fixed_pkg::sm_word_t vel_x,
	output nav_fixed_pkg::sm_word_t vel_y,
	output logic enable_time_n,
	output logic clear_time_n,
	output logic behavior,
	output nav_fsm_pkg::beh_code_e current_beh
);

	logic near_1;
	logic near_2;
	logic near_3;
	logic near_4;
	logic any_near;
	logic err_x_neg;
	logic err_y_neg;
	logic err_y_small;
	nav_fsm_pkg::nav_state_e state;

	proximity_classify #(.safe_dist(safe_dist), .err_tol(err_tol)) u_classify
	(
		.dist_1(dist_1), .dist_2(dist_2), .dist_3(dist_3), .dist_4(dist_4),
		.err_x(err_x), .err_y(err_y),
		.near_1(near_1), .near_2(near_2), .near_3(near_3), .near_4(near_4),
		.any_near(any_near), .err_x_neg(err_x_neg), .err_y_neg(err_y_neg),
		.err_y_small(err_y_small)
	);

	avoid_fsm u_fsm
	(
		.SC_STATEMACHINE_DESC_CLOCK_50(SC_STATEMACHINE_DESC_CLOCK_50),
		.SC_STATEMACHINE_DESC_RESET_InHigh(SC_STATEMACHINE_DESC_RESET_InHigh),
		.near_1(near_1), .near_2(near_2), .near_3(near_3), .near_4(near_4),
		.any_near(any_near), .err_x_neg(err_x_neg), .err_y_neg(err_y_neg),
		.err_y_small(err_y_small), .time_flag_n(time_flag_n), .state(state)
	);

	motion_decode #(.vel_mag(vel_mag)) u_decode
	(
		.state(state), .vel_x(vel_x), .vel_y(vel_y),
		.enable_time_n(enable_time_n), .clear_time_n(clear_time_n),
		.behavior(behavior), .current_beh(current_beh)
	);

endmodule

//--- verilog/motion_decode.sv
//==========================================================
// motion decoder
// Moore outputs of the behavior FSM: velocity commands,
// behavior flag and code, and the wait timer strobes
//==========================================================
`timescale 1ns/10ps

module motion_decode
#(
	parameter nav_fixed_pkg::sm_word_t vel_mag = nav_fixed_pkg::default_vel_mag
)
(
	input  nav_fsm_pkg::nav_state_e state,
	output nav_fixed_pkg::sm_word_t vel_x,
	output nav_fixed_pkg::sm_word_t vel_y,
	output logic enable_time_n,
	output logic clear_time_n,
	output logic behavior,
	output nav_fsm_pkg::beh_code_e current_beh
);

	nav_fsm_pkg::motion_e motion;

	always_comb
	begin
		motion = nav_fsm_pkg::mot_stop;
		enable_time_n = 1'b1;
		clear_time_n = 1'b1;
		behavior = 1'b0; // avoiding unless listed below
		case (state)
			nav_fsm_pkg::st_right_0, nav_fsm_pkg::st_right_1, nav_fsm_pkg::st_right_2:
				motion = nav_fsm_pkg::mot_right;
			nav_fsm_pkg::st_wait_0, nav_fsm_pkg::st_wait_1, nav_fsm_pkg::st_wait_right_2:
			begin
				motion = nav_fsm_pkg::mot_right;
				enable_time_n = 1'b0; // timer runs
			end
			nav_fsm_pkg::st_clear_0, nav_fsm_pkg::st_clear_1, nav_fsm_pkg::st_clear_right_2:
			begin
				motion = nav_fsm_pkg::mot_right;
				clear_time_n = 1'b0; // rearm timer
			end
			nav_fsm_pkg::st_fwd_entry_2, nav_fsm_pkg::st_fwd_2,
			nav_fsm_pkg::st_fwd_entry_3, nav_fsm_pkg::st_fwd_3:
				motion = nav_fsm_pkg::mot_fwd;
			nav_fsm_pkg::st_wait_fwd_2, nav_fsm_pkg::st_wait_fwd_3:
			begin
				motion = nav_fsm_pkg::mot_fwd;
				enable_time_n = 1'b0;
			end
			nav_fsm_pkg::st_clear_fwd_2, nav_fsm_pkg::st_clear_fwd_3:
			begin
				motion = nav_fsm_pkg::mot_fwd;
				clear_time_n = 1'b0;
			end
			nav_fsm_pkg::st_left_3:
				motion = nav_fsm_pkg::mot_left;
			nav_fsm_pkg::st_wait_left_3:
			begin
				motion = nav_fsm_pkg::mot_left;
				enable_time_n = 1'b0;
			end
			nav_fsm_pkg::st_clear_left_3:
			begin
				motion = nav_fsm_pkg::mot_left;
				clear_time_n = 1'b0;
			end
			default:
				behavior = 1'b1; // reset, start, goal, checks
		endcase
	end

	// opcode to sign-magnitude velocity
	always_comb
	begin
		vel_x = '0;
		vel_y = '0;
		case (motion)
			nav_fsm_pkg::mot_right:
				vel_y = {1'b1, vel_mag[nav_fixed_pkg::word_width-2:0]}; // negative y
			nav_fsm_pkg::mot_left:
				vel_y = vel_mag;
			nav_fsm_pkg::mot_fwd:
				vel_x = vel_mag;
			default:
				vel_x = '0; // stop
		endcase
	end

	assign current_beh = behavior ? nav_fsm_pkg::goal_code : nav_fsm_pkg::avoid_code;

endmodule

//--- verilog/avoid_fsm.sv
//==========================================================
// behavior FSM
// switches between go-to-goal and one of four obstacle
// detours, waiting on the external timer between legs
//==========================================================
`timescale 1ns/10ps

module avoid_fsm
(
	input  logic SC_STATEMACHINE_DESC_CLOCK_50,
	input  logic SC_STATEMACHINE_DESC_RESET_InHigh,
	input  logic near_1,
	input  logic near_2,
	input  logic near_3,
	input  logic near_4,
	input  logic any_near,
	input  logic err_x_neg,
	input  logic err_y_neg,
	input  logic err_y_small,
	input  logic time_flag_n,
	output nav_fsm_pkg::nav_state_e state
);

	nav_fsm_pkg::nav_state_e state_next;

	//==========================================================
	// next-state logic
	//==========================================================
	always_comb
	begin
		case (state)
			nav_fsm_pkg::st_reset:
				state_next = nav_fsm_pkg::st_start;
			nav_fsm_pkg::st_start:
				state_next = nav_fsm_pkg::st_goal;
			nav_fsm_pkg::st_goal:
				state_next = any_near ? nav_fsm_pkg::st_avoid_check_0 : nav_fsm_pkg::st_goal;

			// detour 0, sidestep right while sensor 1 sees the obstacle
			nav_fsm_pkg::st_avoid_check_0:
				state_next = !err_y_neg ? nav_fsm_pkg::st_right_0 : nav_fsm_pkg::st_avoid_check_1;
			nav_fsm_pkg::st_right_0:
				state_next = near_1 ? nav_fsm_pkg::st_right_0 : nav_fsm_pkg::st_wait_0;
			nav_fsm_pkg::st_wait_0:
				state_next = !time_flag_n ? nav_fsm_pkg::st_clear_0 : nav_fsm_pkg::st_wait_0;
			nav_fsm_pkg::st_clear_0:
				state_next = nav_fsm_pkg::st_goal;

			// detour 1, sidestep right on sensor 3
			nav_fsm_pkg::st_avoid_check_1:
				state_next = err_y_neg ? nav_fsm_pkg::st_right_1 : nav_fsm_pkg::st_avoid_check_2;
			nav_fsm_pkg::st_right_1:
				state_next = near_3 ? nav_fsm_pkg::st_right_1 : nav_fsm_pkg::st_wait_1;
			nav_fsm_pkg::st_wait_1:
				state_next = !time_flag_n ? nav_fsm_pkg::st_clear_1 : nav_fsm_pkg::st_wait_1;
			nav_fsm_pkg::st_clear_1:
				state_next = nav_fsm_pkg::st_goal;

			// detour 2, forward past sensor 2 then right past sensor 3
			nav_fsm_pkg::st_avoid_check_2:
				if (!err_x_neg && err_y_small)
					state_next = nav_fsm_pkg::st_fwd_entry_2;
				else
					state_next = nav_fsm_pkg::st_avoid_check_3;
			nav_fsm_pkg::st_fwd_entry_2:
				state_next = near_2 ? nav_fsm_pkg::st_fwd_2 : nav_fsm_pkg::st_goal; // side clear
			nav_fsm_pkg::st_fwd_2:
				state_next = near_2 ? nav_fsm_pkg::st_fwd_2 : nav_fsm_pkg::st_wait_fwd_2;
			nav_fsm_pkg::st_wait_fwd_2:
				if (!time_flag_n)
					state_next = nav_fsm_pkg::st_clear_fwd_2;
				else
					state_next = nav_fsm_pkg::st_wait_fwd_2;
			nav_fsm_pkg::st_clear_fwd_2:
				state_next = nav_fsm_pkg::st_right_2;
			nav_fsm_pkg::st_right_2:
				state_next = near_3 ? nav_fsm_pkg::st_right_2 : nav_fsm_pkg::st_wait_right_2;
			nav_fsm_pkg::st_wait_right_2:
				if (!time_flag_n)
					state_next = nav_fsm_pkg::st_clear_right_2;
				else
					state_next = nav_fsm_pkg::st_wait_right_2;
			nav_fsm_pkg::st_clear_right_2:
				state_next = nav_fsm_pkg::st_goal;

			// detour 3, mirror of detour 2 on sensor 4, leaves to the left
			nav_fsm_pkg::st_avoid_check_3:
				if (err_x_neg && err_y_small)
					state_next = nav_fsm_pkg::st_fwd_entry_3;
				else
					state_next = nav_fsm_pkg::st_goal; // no detour applies
			nav_fsm_pkg::st_fwd_entry_3:
				state_next = near_4 ? nav_fsm_pkg::st_fwd_3 : nav_fsm_pkg::st_goal;
			nav_fsm_pkg::st_fwd_3:
				state_next = near_4 ? nav_fsm_pkg::st_fwd_3 : nav_fsm_pkg::st_wait_fwd_3;
			nav_fsm_pkg::st_wait_fwd_3:
				if (!time_flag_n)
					state_next = nav_fsm_pkg::st_clear_fwd_3;
				else
					state_next = nav_fsm_pkg::st_wait_fwd_3;
			nav_fsm_pkg::st_clear_fwd_3:
				state_next = nav_fsm_pkg::st_left_3;
			nav_fsm_pkg::st_left_3:
				state_next = near_3 ? nav_fsm_pkg::st_left_3 : nav_fsm_pkg::st_wait_left_3;
			nav_fsm_pkg::st_wait_left_3:
				if (!time_flag_n)
					state_next = nav_fsm_pkg::st_clear_left_3;
				else
					state_next = nav_fsm_pkg::st_wait_left_3;
			nav_fsm_pkg::st_clear_left_3:
				state_next = nav_fsm_pkg::st_goal;

			default:
				state_next = nav_fsm_pkg::st_reset; // unused codes recover
		endcase
	end

	//==========================================================
	// state register
	//==========================================================
	always_ff @(posedge SC_STATEMACHINE_DESC_CLOCK_50 or posedge SC_STATEMACHINE_DESC_RESET_InHigh)
	begin
		if (SC_STATEMACHINE_DESC_RESET_InHigh)
			state <= nav_fsm_pkg::st_reset;
		else
			state <= state_next;
	end

endmodule

//--- verilog/proximity_classify.sv
//==========================================================
// proximity classifier
// compares the four range sensors against the safe distance
// and reduces the goal errors to sign and tolerance flags
//==========================================================
`timescale 1ns/10ps

module proximity_classify
#(
	parameter nav_fixed_pkg::sm_word_t safe_dist = nav_fixed_pkg::default_safe_dist,
	parameter nav_fixed_pkg::sm_word_t err_tol = nav_fixed_pkg::default_err_tol
)
(
	input  nav_fixed_pkg::sm_word_t dist_1,
	input  nav_fixed_pkg::sm_word_t dist_2,
	input  nav_fixed_pkg::sm_word_t dist_3,
	input  nav_fixed_pkg::sm_word_t dist_4,
	input  nav_fixed_pkg::sm_word_t err_x,
	input  nav_fixed_pkg::sm_word_t err_y,
	output logic near_1,
	output logic near_2,
	output logic near_3,
	output logic near_4,
	output logic any_near,
	output logic err_x_neg,
	output logic err_y_neg,
	output logic err_y_small
);

	localparam int sign_bit = nav_fixed_pkg::word_width - 1;

	assign near_1 = (dist_1 <= safe_dist); // whole word, sign included
	assign near_2 = (dist_2 <= safe_dist);
	assign near_3 = (dist_3 <= safe_dist);
	assign near_4 = (dist_4 <= safe_dist);
	assign any_near = near_1 | near_2 | near_3 | near_4;

	assign err_x_neg = err_x[sign_bit];
	assign err_y_neg = err_y[sign_bit];
	assign err_y_small = (err_y[sign_bit-1:0] <= err_tol[sign_bit-1:0]); // magnitudes only

endmodule

//--- verilog/nav_fsm_pkg.sv
//==========================================================
// nav behavior FSM definitions
// state encoding of the avoidance FSM, the behavior codes
// reported to the host and the motion opcodes
//==========================================================
package nav_fsm_pkg;

	typedef enum logic [4:0]
	{
		st_reset          = 5'd0,
		st_start          = 5'd1,
		st_goal           = 5'd2,
		st_avoid_check_0  = 5'd3,
		st_right_0        = 5'd4,  // detour 0, y error non-negative
		st_avoid_check_1  = 5'd5,
		st_right_1        = 5'd6,  // detour 1, y error negative
		st_avoid_check_2  = 5'd7,
		st_fwd_entry_2    = 5'd8,
		st_fwd_2          = 5'd9,
		st_right_2        = 5'd10,
		st_avoid_check_3  = 5'd11,
		st_fwd_entry_3    = 5'd12,
		st_fwd_3          = 5'd13,
		st_left_3         = 5'd14,
		st_wait_0         = 5'd15,
		st_clear_0        = 5'd16,
		st_wait_1         = 5'd17,
		st_clear_1        = 5'd18,
		st_wait_fwd_2     = 5'd19,
		st_clear_fwd_2    = 5'd20,
		st_wait_right_2   = 5'd21,
		st_clear_right_2  = 5'd22,
		st_wait_fwd_3     = 5'd23,
		st_clear_fwd_3    = 5'd24,
		st_wait_left_3    = 5'd25,
		st_clear_left_3   = 5'd26
	} nav_state_e;

	typedef enum logic [7:0]
	{
		goal_code  = 8'd50,
		avoid_code = 8'd100
	} beh_code_e;

	// right is y negative, left is y positive, forward is x positive
	typedef enum logic [1:0]
	{
		mot_stop  = 2'd0,
		mot_right = 2'd1,
		mot_left  = 2'd2,
		mot_fwd   = 2'd3
	} motion_e;

endpackage

//--- verilog/nav_fixed_pkg.sv
//==========================================================
// nav fixed-point definitions
// sign-magnitude word used for distances, goal errors and
// velocity commands: 1 sign bit, 8 integer bits, 8 fraction
// bits, in centimetres
//==========================================================
package nav_fixed_pkg;

	localparam int word_width = 17; // sign + 8 int + 8 frac
	localparam int frac_bits = 8;

	// top bit set means negative, the rest is the magnitude
	typedef logic [word_width-1:0] sm_word_t;

	//==========================================================
	// default thresholds and speed
	//==========================================================
	localparam sm_word_t default_safe_dist = sm_word_t'(15 << frac_bits); // 15.0 cm
	localparam sm_word_t default_err_tol = sm_word_t'(10 << frac_bits); // 10.0 cm
	localparam sm_word_t default_vel_mag = sm_word_t'(50 << frac_bits); // 50.0 cm/s

endpackage
